//--- rtl/dm_defines.svh
`ifndef DM_DEFINES_SVH
`define DM_DEFINES_SVH

// Flit payload and trailing empty-byte count.
`define DM_DATA_W    64
`define DM_EMPTY_W   3

// Packet slots, one ID per slot.
`define DM_PKT_NUM   16
`define DM_ID_W      4

// Slot size in flits and the matching count and address widths.
`define DM_MAX_FLITS 8
`define DM_FLITS_W   4
`define DM_ADDR_W    7

// Cycles from read request to read data.
`define DM_MEM_LAT   3

// Credits per output channel at reset.
`define DM_CREDITS   8
`define DM_CRED_W    4

`endif

//--- rtl/dm_pkg.sv
`include "dm_defines.svh"

package dm_pkg;

    // Where a packet goes once it leaves the buffer.
    typedef enum logic [1:0] {
        DEST_DROP = 2'd0,
        DEST_PCIE = 2'd1,
        DEST_ETH  = 2'd2
    } pkt_dest_e;

    typedef logic [`DM_ID_W-1:0]   pkt_id_t;
    typedef logic [`DM_ADDR_W-1:0] buf_addr_t;
    typedef logic [`DM_CRED_W-1:0] cred_t;

    typedef struct packed {
        logic [`DM_DATA_W-1:0]  data;
        logic                   sop;
        logic                   eop;
        logic [`DM_EMPTY_W-1:0] empty;
    } flit_t;

    typedef struct packed {
        pkt_id_t                pkt_id;
        logic [`DM_FLITS_W-1:0] flits;
        logic [15:0]            len;
        pkt_dest_e              dest;
    } metadata_t;

    typedef struct packed {
        logic      valid;
        buf_addr_t addr;
        flit_t     flit;
    } buf_wr_t;

    typedef struct packed {
        logic      valid;
        buf_addr_t addr;
        pkt_dest_e dest;
    } rd_req_t;

    typedef struct packed {
        logic      valid;
        pkt_dest_e dest;
        flit_t     flit;
    } rd_resp_t;

endpackage

//--- rtl/free_list.sv
`timescale 1ns/1ps
`include "dm_defines.svh"

module free_list (
    input  logic                clk,
    input  logic                rst,
    output logic                alloc_valid,
    output logic [`DM_ID_W-1:0] alloc_id,
    input  logic                alloc_ready,
    input  logic                rel_valid,
    input  logic [`DM_ID_W-1:0] rel_id
);
    import dm_pkg::*;

    // Depth equals the ID space, so the pointers wrap on their own.
    pkt_id_t           mem [`DM_PKT_NUM];
    pkt_id_t           rd_ptr;
    pkt_id_t           wr_ptr;
    logic [`DM_ID_W:0] count;
    pkt_id_t           init_id;
    logic              init_done;
    logic              push;
    logic              pop;
    pkt_id_t           push_id;

    // The load sequence owns the write port until every ID is in.
    assign push    = !init_done || rel_valid;
    assign push_id = init_done ? rel_id : init_id;
    assign pop     = alloc_valid && alloc_ready;

    assign alloc_valid = init_done && (count != '0);
    assign alloc_id    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_id;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr    <= '0;
            wr_ptr    <= '0;
            count     <= '0;
            init_id   <= '0;
            init_done <= 1'b0;
        end else begin
            if (!init_done) begin
                init_id <= init_id + 1'b1;
                if (init_id == pkt_id_t'(`DM_PKT_NUM - 1)) begin
                    init_done <= 1'b1;
                end
            end
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- rtl/pkt_buffer.sv
`timescale 1ns/1ps
`include "dm_defines.svh"

module pkt_buffer (
    input  logic             clk,
    input  logic             rst,
    input  dm_pkg::buf_wr_t  buf_wr,
    input  dm_pkg::rd_req_t  rd_req,
    output dm_pkg::rd_resp_t rd_resp
);
    import dm_pkg::*;

    localparam int unsigned DEPTH = `DM_PKT_NUM * `DM_MAX_FLITS;

    // Slot i occupies addresses i*DM_MAX_FLITS and up.
    flit_t    mem [DEPTH];
    rd_resp_t pipe [`DM_MEM_LAT];

    // Ingress writes, no back-pressure.
    always_ff @(posedge clk) begin
        if (buf_wr.valid) begin
            mem[buf_wr.addr] <= buf_wr.flit;
        end
    end

    // Read path.
    // The tag rides with its flit through every stage, so
    // a response always names the channel its request was made for.
    always_ff @(posedge clk) begin
        pipe[0].valid <= rd_req.valid;
        pipe[0].dest  <= rd_req.dest;
        pipe[0].flit  <= mem[rd_req.addr];
        for (int i = 1; i < `DM_MEM_LAT; i++) begin
            pipe[i] <= pipe[i-1];
        end
        if (rst) begin
            for (int i = 0; i < `DM_MEM_LAT; i++) begin
                pipe[i].valid <= 1'b0;
            end
        end
    end

    assign rd_resp = pipe[`DM_MEM_LAT-1];

endmodule

//--- rtl/flit_reader.sv
`timescale 1ns/1ps
`include "dm_defines.svh"

module flit_reader (
    input  logic                clk,
    input  logic                rst,
    input  logic                meta_valid,
    input  dm_pkg::metadata_t   meta_data,
    output logic                meta_ready,
    input  logic                disable_pcie,
    input  logic                pcie_pkt_credit,
    input  logic                pcie_meta_credit,
    input  logic                eth_pkt_credit,
    output dm_pkg::rd_req_t     rd_req,
    output logic                rel_valid,
    output logic [`DM_ID_W-1:0] rel_id,
    output logic                acc_meta_valid,
    output dm_pkg::metadata_t   acc_meta
);
    import dm_pkg::*;

    typedef enum logic {
        IDLE,
        READ
    } state_e;

    state_e                 state;
    logic                   run;
    pkt_dest_e              res_dest;
    cred_t                  req_flits;
    logic                   cred_ok;
    logic                   last_read;
    logic                   accept;
    logic [`DM_FLITS_W-1:0] remain;
    pkt_id_t                cur_id;
    cred_t                  pcie_pkt_cred;
    cred_t                  pcie_meta_cred;
    cred_t                  eth_pkt_cred;
    cred_t                  pcie_pkt_take;
    cred_t                  pcie_meta_take;
    cred_t                  eth_pkt_take;

    // With PCIe disabled, anything not dropped goes back to Ethernet.
    always_comb begin
        res_dest = meta_data.dest;
        if (disable_pcie && (meta_data.dest != DEST_DROP)) begin
            res_dest = DEST_ETH;
        end
    end

    assign req_flits = cred_t'(meta_data.flits);

    // Whole packet must fit in the receiver before it starts.
    always_comb begin
        case (res_dest)
            DEST_PCIE: cred_ok = (pcie_pkt_cred >= req_flits) && (pcie_meta_cred != '0);
            DEST_ETH:  cred_ok = (eth_pkt_cred >= req_flits);
            default:   cred_ok = 1'b1;
        endcase
    end

    assign last_read = (state == READ) && (remain == 1);

    // No drop in the last-read cycle, its release would land on this packet's.
    assign meta_ready = run && cred_ok &&
                        ((state == IDLE) || (last_read && (res_dest != DEST_DROP)));
    assign accept     = meta_valid && meta_ready;

    assign acc_meta_valid = accept;
    always_comb begin
        acc_meta      = meta_data;
        acc_meta.dest = res_dest;
    end

    always_comb begin
        pcie_pkt_take  = '0;
        pcie_meta_take = '0;
        eth_pkt_take   = '0;
        if (accept) begin
            case (res_dest)
                DEST_PCIE: begin
                    pcie_pkt_take  = req_flits;
                    pcie_meta_take = cred_t'(1);
                end
                DEST_ETH: eth_pkt_take = req_flits;
                default:  eth_pkt_take = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pcie_pkt_cred  <= cred_t'(`DM_CREDITS);
            pcie_meta_cred <= cred_t'(`DM_CREDITS);
            eth_pkt_cred   <= cred_t'(`DM_CREDITS);
        end else begin
            pcie_pkt_cred  <= pcie_pkt_cred + cred_t'(pcie_pkt_credit) - pcie_pkt_take;
            pcie_meta_cred <= pcie_meta_cred + cred_t'(pcie_meta_credit) - pcie_meta_take;
            eth_pkt_cred   <= eth_pkt_cred + cred_t'(eth_pkt_credit) - eth_pkt_take;
        end
    end

    // Read sequencer, one address per cycle while in READ.
    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= IDLE;
            run          <= 1'b0;
            remain       <= '0;
            rd_req.valid <= 1'b0;
            rel_valid    <= 1'b0;
        end else begin
            run       <= 1'b1;
            rel_valid <= 1'b0;
            if (state == READ) begin
                if (last_read) begin
                    rel_valid    <= 1'b1;
                    rel_id       <= cur_id;
                    state        <= IDLE;
                    rd_req.valid <= 1'b0;
                end else begin
                    remain      <= remain - 1'b1;
                    rd_req.addr <= rd_req.addr + 1'b1;
                end
            end
            if (accept) begin
                if (res_dest == DEST_DROP) begin
                    rel_valid <= 1'b1;
                    rel_id    <= meta_data.pkt_id;
                end else begin
                    state        <= READ;
                    remain       <= meta_data.flits;
                    cur_id       <= meta_data.pkt_id;
                    rd_req.valid <= 1'b1;
                    rd_req.addr  <= buf_addr_t'(meta_data.pkt_id) *
                                    buf_addr_t'(`DM_MAX_FLITS);
                    rd_req.dest  <= res_dest;
                end
            end
        end
    end

endmodule

//--- rtl/egress_router.sv
`timescale 1ns/1ps

module egress_router (
    input  logic              clk,
    input  logic              rst,
    input  dm_pkg::rd_resp_t  rd_resp,
    input  logic              acc_meta_valid,
    input  dm_pkg::metadata_t acc_meta,
    output logic              pcie_pkt_valid,
    output dm_pkg::flit_t     pcie_pkt,
    output logic              eth_pkt_valid,
    output dm_pkg::flit_t     eth_pkt,
    output logic              pcie_meta_valid,
    output dm_pkg::metadata_t pcie_meta
);
    import dm_pkg::*;

    logic to_pcie;
    logic to_eth;
    logic meta_to_pcie;

    // Steering follows the tag carried back from the buffer.
    assign to_pcie      = rd_resp.valid && (rd_resp.dest == DEST_PCIE);
    assign to_eth       = rd_resp.valid && (rd_resp.dest == DEST_ETH);

    // Only PCIe packets get a metadata word downstream.
    assign meta_to_pcie = acc_meta_valid && (acc_meta.dest == DEST_PCIE);

    // Each payload register loads only for its own channel.
    always_ff @(posedge clk) begin
        if (to_pcie) begin
            pcie_pkt <= rd_resp.flit;
        end
        if (to_eth) begin
            eth_pkt <= rd_resp.flit;
        end
        if (meta_to_pcie) begin
            pcie_meta <= acc_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pcie_pkt_valid  <= 1'b0;
            eth_pkt_valid   <= 1'b0;
            pcie_meta_valid <= 1'b0;
        end else begin
            pcie_pkt_valid  <= to_pcie;
            eth_pkt_valid   <= to_eth;
            pcie_meta_valid <= meta_to_pcie;
        end
    end

endmodule

//--- rtl/data_mover_top.sv
`timescale 1ns/1ps
`include "dm_defines.svh"

module data_mover_top (
    input  logic                clk,
    input  logic                rst,

    // Free packet IDs for the ingress agent.
    output logic                alloc_valid,
    output logic [`DM_ID_W-1:0] alloc_id,
    input  logic                alloc_ready,

    input  dm_pkg::buf_wr_t     buf_wr,

    input  logic                meta_valid,
    input  dm_pkg::metadata_t   meta_data,
    output logic                meta_ready,

    input  logic                disable_pcie,

    output logic                pcie_pkt_valid,
    output dm_pkg::flit_t       pcie_pkt,
    input  logic                pcie_pkt_credit,

    output logic                pcie_meta_valid,
    output dm_pkg::metadata_t   pcie_meta,
    input  logic                pcie_meta_credit,

    output logic                eth_pkt_valid,
    output dm_pkg::flit_t       eth_pkt,
    input  logic                eth_pkt_credit
);
    import dm_pkg::*;

    rd_req_t   rd_req;
    rd_resp_t  rd_resp;
    logic      rel_valid;
    pkt_id_t   rel_id;
    logic      acc_meta_valid;
    metadata_t acc_meta;

    free_list free_list0 (
        .clk         (clk),
        .rst         (rst),
        .alloc_valid (alloc_valid),
        .alloc_id    (alloc_id),
        .alloc_ready (alloc_ready),
        .rel_valid   (rel_valid),
        .rel_id      (rel_id)
    );

    pkt_buffer pkt_buffer0 (
        .clk     (clk),
        .rst     (rst),
        .buf_wr  (buf_wr),
        .rd_req  (rd_req),
        .rd_resp (rd_resp)
    );

    flit_reader flit_reader0 (
        .clk              (clk),
        .rst              (rst),
        .meta_valid       (meta_valid),
        .meta_data        (meta_data),
        .meta_ready       (meta_ready),
        .disable_pcie     (disable_pcie),
        .pcie_pkt_credit  (pcie_pkt_credit),
        .pcie_meta_credit (pcie_meta_credit),
        .eth_pkt_credit   (eth_pkt_credit),
        .rd_req           (rd_req),
        .rel_valid        (rel_valid),
        .rel_id           (rel_id),
        .acc_meta_valid   (acc_meta_valid),
        .acc_meta         (acc_meta)
    );

    egress_router egress_router0 (
        .clk             (clk),
        .rst             (rst),
        .rd_resp         (rd_resp),
        .acc_meta_valid  (acc_meta_valid),
        .acc_meta        (acc_meta),
        .pcie_pkt_valid  (pcie_pkt_valid),
        .pcie_pkt        (pcie_pkt),
        .eth_pkt_valid   (eth_pkt_valid),
        .eth_pkt         (eth_pkt),
        .pcie_meta_valid (pcie_meta_valid),
        .pcie_meta       (pcie_meta)
    );

endmodule

//--- tb/tb_data_mover.sv
`timescale 1ns/1ps
`include "dm_defines.svh"

module tb_data_mover;
    import dm_pkg::*;

    typedef struct packed {
        pkt_dest_e              dest;
        logic [`DM_FLITS_W-1:0] flits;
        logic [`DM_EMPTY_W-1:0] empty;
        logic                   dis;
        logic                   hold;
    } row_t;

    localparam int NROWS    = 20;
    localparam int TIMEOUT  = 500;
    localparam int HOLD_LEN = 40;

    // Columns are dest, flits, empty, disable_pcie, credit hold.
    localparam row_t ROWS [NROWS] = '{
        '{DEST_PCIE, 4'd3, 3'd2, 1'b0, 1'b0},
        '{DEST_ETH,  4'd1, 3'd5, 1'b0, 1'b0},
        '{DEST_DROP, 4'd4, 3'd0, 1'b0, 1'b0},
        '{DEST_PCIE, 4'd8, 3'd0, 1'b0, 1'b0},
        '{DEST_PCIE, 4'd2, 3'd7, 1'b1, 1'b0},
        '{DEST_ETH,  4'd5, 3'd1, 1'b0, 1'b0},
        '{DEST_DROP, 4'd1, 3'd0, 1'b1, 1'b0},
        '{DEST_PCIE, 4'd6, 3'd3, 1'b0, 1'b1},
        '{DEST_PCIE, 4'd8, 3'd4, 1'b0, 1'b0},
        '{DEST_ETH,  4'd8, 3'd0, 1'b0, 1'b0},
        '{DEST_ETH,  4'd7, 3'd6, 1'b0, 1'b1},
        '{DEST_PCIE, 4'd1, 3'd1, 1'b0, 1'b0},
        '{DEST_PCIE, 4'd4, 3'd0, 1'b1, 1'b0},
        '{DEST_DROP, 4'd8, 3'd0, 1'b0, 1'b0},
        '{DEST_ETH,  4'd3, 3'd3, 1'b0, 1'b0},
        '{DEST_PCIE, 4'd5, 3'd2, 1'b0, 1'b0},
        '{DEST_PCIE, 4'd2, 3'd0, 1'b0, 1'b0},
        '{DEST_ETH,  4'd6, 3'd4, 1'b0, 1'b0},
        '{DEST_DROP, 4'd2, 3'd0, 1'b0, 1'b0},
        '{DEST_PCIE, 4'd7, 3'd5, 1'b0, 1'b0}
    };

    logic                clk;
    logic                rst;
    logic                alloc_valid;
    logic [`DM_ID_W-1:0] alloc_id;
    logic                alloc_ready;
    buf_wr_t             buf_wr;
    logic                meta_valid;
    metadata_t           meta_data;
    logic                meta_ready;
    logic                disable_pcie;
    logic                pcie_pkt_valid;
    flit_t               pcie_pkt;
    logic                pcie_pkt_credit;
    logic                pcie_meta_valid;
    metadata_t           pcie_meta;
    logic                pcie_meta_credit;
    logic                eth_pkt_valid;
    flit_t               eth_pkt;
    logic                eth_pkt_credit;

    int        errors;
    int        checks;
    int        timeouts;
    int        seed;
    int        hold_cycles;
    logic      hold_now;
    int        pcie_owed;
    int        meta_owed;
    int        eth_owed;
    flit_t     exp_pcie [$];
    flit_t     exp_eth [$];
    metadata_t exp_meta [$];
    pkt_id_t   exp_free [$];
    pkt_id_t   held [$];

    data_mover_top dut0 (
        .clk              (clk),
        .rst              (rst),
        .alloc_valid      (alloc_valid),
        .alloc_id         (alloc_id),
        .alloc_ready      (alloc_ready),
        .buf_wr           (buf_wr),
        .meta_valid       (meta_valid),
        .meta_data        (meta_data),
        .meta_ready       (meta_ready),
        .disable_pcie     (disable_pcie),
        .pcie_pkt_valid   (pcie_pkt_valid),
        .pcie_pkt         (pcie_pkt),
        .pcie_pkt_credit  (pcie_pkt_credit),
        .pcie_meta_valid  (pcie_meta_valid),
        .pcie_meta        (pcie_meta),
        .pcie_meta_credit (pcie_meta_credit),
        .eth_pkt_valid    (eth_pkt_valid),
        .eth_pkt          (eth_pkt),
        .eth_pkt_credit   (eth_pkt_credit)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic error_line(string msg);
        errors++;
        $display("ERROR %0t: %s", $time, msg);
    endtask

    task automatic report_timeout(string what);
        timeouts++;
        $display("Timed out waiting for %s", what);
    endtask

    task automatic check_flit(string ch, flit_t got, flit_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s got %h sop %b eop %b empty %0d", $time, ch,
                     got.data, got.sop, got.eop, got.empty);
            $display("      expected %h sop %b eop %b empty %0d",
                     exp.data, exp.sop, exp.eop, exp.empty);
        end
    endtask

    task automatic check_meta(metadata_t got, metadata_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: pcie_meta got id %0d flits %0d len %0d dest %0d", $time,
                     got.pkt_id, got.flits, got.len, got.dest);
            $display("      expected id %0d flits %0d len %0d dest %0d",
                     exp.pkt_id, exp.flits, exp.len, exp.dest);
        end
    endtask

    task automatic check_id(pkt_id_t got, pkt_id_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: alloc_id %0d, expected %0d", $time, got, exp);
        end
    endtask

    // Pops one ID, returns one nanosecond after the handshake edge.
    task automatic take_id(output pkt_id_t id);
        int waited;
        waited      = 0;
        id          = '0;
        alloc_ready = 1'b1;
        do begin
            @(posedge clk);
            waited++;
        end while (!alloc_valid && waited < TIMEOUT);
        if (alloc_valid) begin
            id = alloc_id;
        end else begin
            report_timeout("a free packet ID");
        end
        #1;
        alloc_ready = 1'b0;
    endtask

    task automatic write_packet(pkt_id_t id, row_t r, pkt_dest_e rdest);
        flit_t f;
        for (int k = 0; k < int'(r.flits); k++) begin
            f.data       = {$random(seed), $random(seed)};
            f.sop        = (k == 0);
            f.eop        = (k == int'(r.flits) - 1);
            f.empty      = f.eop ? r.empty : '0;
            buf_wr.valid = 1'b1;
            buf_wr.addr  = buf_addr_t'(int'(id) * `DM_MAX_FLITS + k);
            buf_wr.flit  = f;
            if (rdest == DEST_PCIE) begin
                exp_pcie.push_back(f);
            end else if (rdest == DEST_ETH) begin
                exp_eth.push_back(f);
            end
            @(posedge clk);
            #1;
        end
        buf_wr.valid = 1'b0;
    endtask

    task automatic send_meta(metadata_t m);
        int waited;
        waited     = 0;
        meta_valid = 1'b1;
        meta_data  = m;
        do begin
            @(posedge clk);
            waited++;
        end while (!meta_ready && waited < TIMEOUT);
        if (!meta_ready) begin
            report_timeout("meta_ready");
        end
        #1;
        meta_valid = 1'b0;
    endtask

    // Receivers: check every item, keep occupancy, hand credits back one per cycle.
    always @(posedge clk) begin
        if (rst) begin
            if (pcie_pkt_valid || pcie_meta_valid || eth_pkt_valid ||
                alloc_valid || meta_ready) begin
                error_line("output valid or meta_ready high during reset");
            end
        end else begin
            if (pcie_pkt_valid) begin
                pcie_owed++;
                if (exp_pcie.size() == 0) begin
                    error_line("unexpected flit on pcie_pkt");
                end else begin
                    check_flit("pcie_pkt", pcie_pkt, exp_pcie.pop_front());
                end
            end
            if (eth_pkt_valid) begin
                eth_owed++;
                if (exp_eth.size() == 0) begin
                    error_line("unexpected flit on eth_pkt");
                end else begin
                    check_flit("eth_pkt", eth_pkt, exp_eth.pop_front());
                end
            end
            if (pcie_meta_valid) begin
                meta_owed++;
                if (exp_meta.size() == 0) begin
                    error_line("unexpected word on pcie_meta");
                end else begin
                    check_meta(pcie_meta, exp_meta.pop_front());
                end
            end
            if (pcie_owed > `DM_CREDITS || meta_owed > `DM_CREDITS ||
                eth_owed > `DM_CREDITS) begin
                error_line("receiver overrun, more items than credits");
            end
        end
        hold_now = (hold_cycles > 0);
        if (hold_now) begin
            hold_cycles--;
        end
        #1;
        pcie_pkt_credit  = !hold_now && (pcie_owed > 0);
        pcie_meta_credit = !hold_now && (meta_owed > 0);
        eth_pkt_credit   = !hold_now && (eth_owed > 0);
        if (pcie_pkt_credit) pcie_owed--;
        if (pcie_meta_credit) meta_owed--;
        if (eth_pkt_credit) eth_owed--;
    end

    initial begin
        pkt_id_t   id;
        pkt_dest_e rdest;
        metadata_t m;
        int        waited;
        rst              = 1'b1;
        alloc_ready      = 1'b0;
        buf_wr           = '0;
        meta_valid       = 1'b0;
        meta_data        = '0;
        disable_pcie     = 1'b0;
        pcie_pkt_credit  = 1'b0;
        pcie_meta_credit = 1'b0;
        eth_pkt_credit   = 1'b0;
        errors           = 0;
        checks           = 0;
        timeouts         = 0;
        hold_cycles      = 0;
        pcie_owed        = 0;
        meta_owed        = 0;
        eth_owed         = 0;
        seed             = 32'hfaf8_6136;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        // No ID may show while the free list loads.
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!alloc_valid && waited < TIMEOUT);
        if (!alloc_valid) begin
            report_timeout("the free list load");
        end else if (waited <= `DM_PKT_NUM) begin
            error_line("alloc_valid rose before the ID load finished");
        end
        #1;
        for (int i = 0; i < `DM_PKT_NUM && timeouts == 0; i++) begin
            take_id(id);
            check_id(id, pkt_id_t'(i));
            held.push_back(id);
        end
        repeat (8) begin
            @(posedge clk);
            if (alloc_valid) begin
                error_line("alloc_valid high with every ID taken");
            end
        end
        #1;

        for (int r = 0; r < NROWS && timeouts == 0; r++) begin
            if (held.size() > 0) begin
                id = held.pop_front();
            end else begin
                take_id(id);
                check_id(id, exp_free.pop_front());
            end
            rdest = ROWS[r].dest;
            if (ROWS[r].dis && rdest != DEST_DROP) begin
                rdest = DEST_ETH;
            end
            write_packet(id, ROWS[r], rdest);
            m.pkt_id = id;
            m.flits  = ROWS[r].flits;
            m.len    = 16'(int'(ROWS[r].flits) * (`DM_DATA_W / 8) - int'(ROWS[r].empty));
            m.dest   = ROWS[r].dest;
            if (rdest == DEST_PCIE) begin
                exp_meta.push_back(m);
            end
            disable_pcie = ROWS[r].dis;
            if (ROWS[r].hold) begin
                hold_cycles = HOLD_LEN;
            end
            send_meta(m);
            // Released IDs come back in acceptance order.
            exp_free.push_back(id);
        end

        waited = 0;
        while (exp_pcie.size() + exp_eth.size() + exp_meta.size() != 0 &&
               waited < TIMEOUT && timeouts == 0) begin
            @(posedge clk);
            waited++;
        end
        if (exp_pcie.size() + exp_eth.size() + exp_meta.size() != 0) begin
            report_timeout("the remaining packets");
        end
        repeat (20) @(posedge clk);

        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+rtl
rtl/dm_pkg.sv
rtl/free_list.sv
rtl/pkt_buffer.sv
rtl/flit_reader.sv
rtl/egress_router.sv
rtl/data_mover_top.sv
tb/tb_data_mover.sv

//--- Makefile
TOP := tb_data_mover

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 -f compile.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

lint:
	verilator --lint-only -Wall -f compile.f --top-module data_mover_top

clean:
	rm -rf obj_dir
